// File: common/pipe_isa_pkg.sv
`default_nettype none

package pipe_isa_pkg;

   // datapath and instruction widths
   localparam int DATA_W    = 8;
   localparam int INST_W    = 8;
   localparam int REG_IDX_W = 2;
   localparam int OP_W      = 2;
   localparam int IMM_W     = 4;

   typedef logic [DATA_W-1:0]    data_t;
   typedef logic [INST_W-1:0]    inst_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   typedef logic [OP_W-1:0]      op_t;
   typedef logic [IMM_W-1:0]     imm_t;

   localparam op_t OP_NOP  = 2'd0;
   localparam op_t OP_ADD  = 2'd1;
   localparam op_t OP_SET  = 2'd2;
   localparam op_t OP_NAND = 2'd3;

   // field positions, op | rs1 | rs2 | rd
   // SET reuses rs1/rs2 bits as imm
   localparam int OP_HI  = 7;
   localparam int OP_LO  = 6;
   localparam int RS1_HI = 5;
   localparam int RS1_LO = 4;
   localparam int RS2_HI = 3;
   localparam int RS2_LO = 2;
   localparam int RD_HI  = 1;
   localparam int RD_LO  = 0;
   localparam int IMM_HI = 5;
   localparam int IMM_LO = 2;

endpackage

`default_nettype wire

// File: common/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

   // architectural register count
   localparam int NUM_REGS = 4;

   // where the newest pending write to a register sits
   // high bit set while computed in EX
   // low bit set while waiting in WB
   typedef logic [1:0] fwd_loc_t;

   // no pending write so read the register file
   localparam fwd_loc_t LOC_RF = 2'b00;

   // result held in EX/WB
   localparam fwd_loc_t LOC_WB = 2'b01;

   // result being computed in EX takes priority over WB
   localparam fwd_loc_t LOC_EX = 2'b10;

endpackage

`default_nettype wire

// File: common/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded instruction from ID/EX into the execute stage
interface issue_if;
   import pipe_isa_pkg::*;

   logic     valid;
   logic     ready;
   op_t      op;
   reg_idx_t rd;
   logic     reg_wen;
   data_t    operand1;
   data_t    operand2;

   modport producer (
      output valid,
      input  ready,
      output op,
      output rd,
      output reg_wen,
      output operand1,
      output operand2
   );

   modport consumer (
      input  valid,
      output ready,
      input  op,
      input  rd,
      input  reg_wen,
      input  operand1,
      input  operand2
   );

endinterface

`default_nettype wire

// File: common/fwd_if.sv
`timescale 1ns/1ps
`default_nettype none

// pending write of one stage
// go means the stage moves its item on this edge
interface fwd_if;
   import pipe_isa_pkg::*;

   logic     go;
   logic     wen;
   reg_idx_t wdst;
   data_t    val;

   modport producer (
      output go,
      output wen,
      output wdst,
      output val
   );

   modport reader (
      input  go,
      input  wen,
      input  wdst,
      input  val
   );

   // register file write port
   modport writer (
      input  go,
      input  wen,
      input  wdst,
      input  val
   );

endinterface

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  logic                   clk,
   input  logic                   rst,
   fwd_if.writer                  wb_fwd,
   input  pipe_isa_pkg::reg_idx_t rs1,
   input  pipe_isa_pkg::reg_idx_t rs2,
   output pipe_isa_pkg::data_t    rs1_val,
   output pipe_isa_pkg::data_t    rs2_val,
   input  pipe_isa_pkg::reg_idx_t rf_read_addr,
   output pipe_isa_pkg::data_t    rf_read_data
);
   import pipe_isa_pkg::*;
   import pipe_ctrl_pkg::*;

   data_t regs [NUM_REGS];

   // single write port from WB
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_fwd.go && wb_fwd.wen) begin
         regs[wb_fwd.wdst] <= wb_fwd.val;
      end
   end

   // operand reads for ID
   assign rs1_val = regs[rs1];
   assign rs2_val = regs[rs2];

   // debug read port
   assign rf_read_data = regs[rf_read_addr];

endmodule

`default_nettype wire

// File: hdl/scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    id_go,
   input  logic                    id_wen,
   input  pipe_isa_pkg::reg_idx_t  id_rd,
   fwd_if.reader                   ex_fwd,
   fwd_if.reader                   wb_fwd,
   input  pipe_isa_pkg::reg_idx_t  rs1,
   input  pipe_isa_pkg::reg_idx_t  rs2,
   output pipe_ctrl_pkg::fwd_loc_t rs1_loc,
   output pipe_ctrl_pkg::fwd_loc_t rs2_loc
);
   import pipe_isa_pkg::*;
   import pipe_ctrl_pkg::*;

   fwd_loc_t            sb_q [NUM_REGS];
   fwd_loc_t            sb_d [NUM_REGS];
   logic [NUM_REGS-1:0] ex_pend;
   logic [NUM_REGS-1:0] wb_pend;

   // ID entry sets EX, EX move shifts to WB, WB move clears
   always_comb begin
      logic ex_bit;
      logic wb_bit;
      for (int i = 0; i < NUM_REGS; i++) begin
         ex_pend[i] = (sb_q[i] & LOC_EX) != LOC_RF;
         wb_pend[i] = (sb_q[i] & LOC_WB) != LOC_RF;
         ex_bit = id_go ? (id_wen && id_rd == reg_idx_t'(i))
                        : (ex_pend[i] && !ex_fwd.go);
         wb_bit = ex_fwd.go ? (ex_fwd.wen && ex_fwd.wdst == reg_idx_t'(i))
                            : (wb_pend[i] && !(wb_fwd.go && wb_fwd.wdst == reg_idx_t'(i)));
         sb_d[i] = (ex_bit ? LOC_EX : LOC_RF) | (wb_bit ? LOC_WB : LOC_RF);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            sb_q[i] <= LOC_RF;
         end
      end else begin
         for (int i = 0; i < NUM_REGS; i++) begin
            sb_q[i] <= sb_d[i];
         end
      end
   end

   // lookups for the two sources in ID
   assign rs1_loc = sb_q[rs1];
   assign rs2_loc = sb_q[rs2];

   // one item each in ID/EX and EX/WB
   a_one_pending: assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(ex_pend) && $onehot0(wb_pend)
   );

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
   input  logic      clk,
   input  logic      rst,
   input  logic      stallex,
   input  logic      stallwb,
   issue_if.consumer issue,
   fwd_if.producer   ex_fwd,
   fwd_if.producer   wb_fwd
);
   import pipe_isa_pkg::*;

   logic     ex_go;
   data_t    alu_result;

   // EX/WB register
   logic     ex_wb_valid;
   logic     ex_wb_wen;
   reg_idx_t ex_wb_rd;
   data_t    ex_wb_val;

   // ------------------------------------------------------------------
   // EX
   // ------------------------------------------------------------------
   always_comb begin
      case (issue.op)
         OP_ADD:  alu_result = issue.operand1 + issue.operand2;
         OP_SET:  alu_result = issue.operand1;
         OP_NAND: alu_result = ~(issue.operand1 & issue.operand2);
         default: alu_result = '0;
      endcase
   end

   // free slot in EX/WB, or the one there leaves now
   assign issue.ready = !stallex && (!ex_wb_valid || !stallwb);
   assign ex_go       = issue.valid && issue.ready;

   assign ex_fwd.go   = ex_go;
   assign ex_fwd.wen  = issue.valid && issue.reg_wen;
   assign ex_fwd.wdst = issue.rd;
   assign ex_fwd.val  = alu_result;

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_wb_valid <= 1'b0;
      end else if (ex_go) begin
         ex_wb_valid <= 1'b1;
      end else if (wb_fwd.go) begin
         ex_wb_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ex_go) begin
         ex_wb_wen <= issue.reg_wen;
         ex_wb_rd  <= issue.rd;
         ex_wb_val <= alu_result;
      end
   end

   // ------------------------------------------------------------------
   // WB
   // ------------------------------------------------------------------
   assign wb_fwd.go   = ex_wb_valid && !stallwb;
   assign wb_fwd.wen  = ex_wb_wen;
   assign wb_fwd.wdst = ex_wb_rd;
   assign wb_fwd.val  = ex_wb_val;

   // a held writeback keeps its payload
   a_wb_hold: assert property (
      @(posedge clk) disable iff (rst)
      (ex_wb_valid && !wb_fwd.go) |=> ($stable(ex_wb_val) && $stable(ex_wb_rd))
   );

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  logic                    clk,
   input  logic                    rst,
   input  pipe_isa_pkg::inst_t     inst,
   input  logic                    inst_valid,
   output logic                    inst_ready,
   issue_if.producer               issue,
   fwd_if.reader                   ex_fwd,
   fwd_if.reader                   wb_fwd,
   output logic                    id_go,
   output logic                    id_wen,
   output pipe_isa_pkg::reg_idx_t  id_rd,
   output pipe_isa_pkg::reg_idx_t  rs1,
   output pipe_isa_pkg::reg_idx_t  rs2,
   input  pipe_ctrl_pkg::fwd_loc_t rs1_loc,
   input  pipe_ctrl_pkg::fwd_loc_t rs2_loc,
   input  pipe_isa_pkg::data_t     rs1_val,
   input  pipe_isa_pkg::data_t     rs2_val
);
   import pipe_isa_pkg::*;
   import pipe_ctrl_pkg::*;

   logic  if_id_valid;
   inst_t if_id_inst;
   logic  id_ready;
   logic  if_go;
   op_t   op;
   imm_t  imm;
   data_t rs1_fwd;
   data_t rs2_fwd;

   // EX holds the newest value, then WB, then the register file
   function automatic data_t pick_src(input fwd_loc_t loc, input data_t rf_val,
                                      input data_t wb_val, input data_t ex_val);
      data_t val;
      if ((loc & LOC_EX) != LOC_RF)
         val = ex_val;
      else if ((loc & LOC_WB) != LOC_RF)
         val = wb_val;
      else
         val = rf_val;
      return val;
   endfunction

   // ------------------------------------------------------------------
   // IF/ID
   // ------------------------------------------------------------------
   assign id_ready   = !issue.valid || issue.ready;
   assign inst_ready = !if_id_valid || id_ready;
   assign if_go      = inst_valid && inst_ready;
   assign id_go      = if_id_valid && id_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         if_id_valid <= 1'b0;
      end else if (if_go) begin
         if_id_valid <= 1'b1;
      end else if (id_go) begin
         if_id_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (if_go) begin
         if_id_inst <= inst;
      end
   end

   // field decode
   assign op     = if_id_inst[OP_HI:OP_LO];
   assign rs1    = if_id_inst[RS1_HI:RS1_LO];
   assign rs2    = if_id_inst[RS2_HI:RS2_LO];
   assign id_rd  = if_id_inst[RD_HI:RD_LO];
   assign imm    = if_id_inst[IMM_HI:IMM_LO];
   assign id_wen = (op != OP_NOP);

   assign rs1_fwd = pick_src(rs1_loc, rs1_val, wb_fwd.val, ex_fwd.val);
   assign rs2_fwd = pick_src(rs2_loc, rs2_val, wb_fwd.val, ex_fwd.val);

   // ------------------------------------------------------------------
   // ID/EX
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         issue.valid <= 1'b0;
      end else if (id_go) begin
         issue.valid <= 1'b1;
      end else if (issue.ready) begin
         issue.valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (id_go) begin
         issue.op       <= op;
         issue.rd       <= id_rd;
         issue.reg_wen  <= id_wen;
         // SET carries its zero-extended immediate as operand1
         issue.operand1 <= (op == OP_SET) ? data_t'(imm) : rs1_fwd;
         issue.operand2 <= rs2_fwd;
      end
   end

   // an item only enters ID/EX from IF/ID
   a_issue_from_id: assert property (
      @(posedge clk) disable iff (rst)
      $rose(issue.valid) |-> $past(id_go)
   );

endmodule

`default_nettype wire

// File: hdl/pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_top (
   input  logic                   clk,
   input  logic                   rst,
   input  pipe_isa_pkg::inst_t    inst,
   input  logic                   inst_valid,
   output logic                   inst_ready,
   input  logic                   stallex,
   input  logic                   stallwb,
   input  pipe_isa_pkg::reg_idx_t rf_read_addr,
   output pipe_isa_pkg::data_t    rf_read_data
);
   import pipe_isa_pkg::*;
   import pipe_ctrl_pkg::*;

   // ID to scoreboard
   logic     id_go;
   logic     id_wen;
   reg_idx_t id_rd;

   // operand lookups
   reg_idx_t rs1;
   reg_idx_t rs2;
   fwd_loc_t rs1_loc;
   fwd_loc_t rs2_loc;
   data_t    rs1_val;
   data_t    rs2_val;

   issue_if issue ();
   fwd_if   ex_fwd ();
   fwd_if   wb_fwd ();

   decode_stage i_decode (
      .clk        (clk),
      .rst        (rst),
      .inst       (inst),
      .inst_valid (inst_valid),
      .inst_ready (inst_ready),
      .issue      (issue.producer),
      .ex_fwd     (ex_fwd.reader),
      .wb_fwd     (wb_fwd.reader),
      .id_go      (id_go),
      .id_wen     (id_wen),
      .id_rd      (id_rd),
      .rs1        (rs1),
      .rs2        (rs2),
      .rs1_loc    (rs1_loc),
      .rs2_loc    (rs2_loc),
      .rs1_val    (rs1_val),
      .rs2_val    (rs2_val)
   );

   execute_stage i_execute (
      .clk     (clk),
      .rst     (rst),
      .stallex (stallex),
      .stallwb (stallwb),
      .issue   (issue.consumer),
      .ex_fwd  (ex_fwd.producer),
      .wb_fwd  (wb_fwd.producer)
   );

   scoreboard i_scoreboard (
      .clk     (clk),
      .rst     (rst),
      .id_go   (id_go),
      .id_wen  (id_wen),
      .id_rd   (id_rd),
      .ex_fwd  (ex_fwd.reader),
      .wb_fwd  (wb_fwd.reader),
      .rs1     (rs1),
      .rs2     (rs2),
      .rs1_loc (rs1_loc),
      .rs2_loc (rs2_loc)
   );

   reg_file i_reg_file (
      .clk          (clk),
      .rst          (rst),
      .wb_fwd       (wb_fwd.writer),
      .rs1          (rs1),
      .rs2          (rs2),
      .rs1_val      (rs1_val),
      .rs2_val      (rs2_val),
      .rf_read_addr (rf_read_addr),
      .rf_read_data (rf_read_data)
   );

endmodule

`default_nettype wire

// File: verif/pipe_model.sv
`timescale 1ns/1ps
`default_nettype none

// architectural register state, updated in program order at acceptance
module pipe_model (
   input  logic            clk,
   input  logic            rst,
   input  logic            accept,
   input  logic [7:0]      inst,
   output logic [3:0][7:0] regs
);

   logic [1:0] op;
   logic [1:0] src1;
   logic [1:0] src2;
   logic [1:0] dst;
   logic [7:0] imm_ext;

   // op | rs1 | rs2 | rd, SET takes bits 5:2 as its immediate
   assign op      = inst[7:6];
   assign src1    = inst[5:4];
   assign src2    = inst[3:2];
   assign dst     = inst[1:0];
   assign imm_ext = {4'b0000, inst[5:2]};

   always_ff @(posedge clk) begin
      if (rst) begin
         regs <= '0;
      end else if (accept) begin
         case (op)
            2'd1: regs[dst] <= regs[src1] + regs[src2];
            2'd2: regs[dst] <= imm_ext;
            2'd3: regs[dst] <= ~(regs[src1] & regs[src2]);
            // NOP
            default: regs <= regs;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verif/pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_tb;

   localparam int CLK_HALF     = 20;
   localparam int RESET_CYCLES = 3;
   localparam int DRAIN_CYCLES = 4;
   localparam int NUM_TESTS    = 5;
   localparam int SET_INSTS    = 4;
   localparam int CHAIN_INSTS  = 16;
   localparam int NOP_INSTS    = 12;
   localparam int RAND_CYCLES  = 400;
   localparam int STIM_CYCLES  =
      RESET_CYCLES + SET_INSTS + CHAIN_INSTS + NOP_INSTS + RAND_CYCLES;
   // each test ends with a drain, four register reads and one spare edge
   localparam int WATCHDOG_CYCLES = 2 * (STIM_CYCLES + NUM_TESTS * (DRAIN_CYCLES + 5));

   localparam logic [1:0] OPC_NOP  = 2'd0;
   localparam logic [1:0] OPC_ADD  = 2'd1;
   localparam logic [1:0] OPC_SET  = 2'd2;
   localparam logic [1:0] OPC_NAND = 2'd3;

   logic            clk;
   logic            rst;
   logic [7:0]      inst;
   logic            inst_valid;
   logic            inst_ready;
   logic            stallex;
   logic            stallwb;
   logic [1:0]      rf_read_addr;
   logic [7:0]      rf_read_data;
   logic [3:0][7:0] model_regs;

   // offered instruction was taken on the last edge
   logic taken;
   int   test_errs;
   int   tests_run;
   int   tests_failed;

   pipe_top i_dut (
      .clk          (clk),
      .rst          (rst),
      .inst         (inst),
      .inst_valid   (inst_valid),
      .inst_ready   (inst_ready),
      .stallex      (stallex),
      .stallwb      (stallwb),
      .rf_read_addr (rf_read_addr),
      .rf_read_data (rf_read_data)
   );

   pipe_model i_model (
      .clk    (clk),
      .rst    (rst),
      .accept (inst_valid && inst_ready),
      .inst   (inst),
      .regs   (model_regs)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   function automatic logic [7:0] encode(input logic [1:0] op, input logic [1:0] a,
                                         input logic [1:0] b, input logic [1:0] d);
      return {op, a, b, d};
   endfunction

   // ------------------------------------------------------------------
   // stimulus helpers are entered just after a rising edge
   // ------------------------------------------------------------------
   task automatic send_inst(input logic [7:0] word);
      inst       <= word;
      inst_valid <= 1'b1;
      @(negedge clk);
      while (!inst_ready) begin
         @(negedge clk);
      end
      @(posedge clk);
      taken = 1'b1;
   endtask

   task automatic drain_pipe();
      logic busy;
      stallex <= 1'b0;
      stallwb <= 1'b0;
      busy = inst_valid && !taken;
      while (busy) begin
         @(negedge clk);
         busy = !inst_ready;
         @(posedge clk);
      end
      inst_valid <= 1'b0;
      taken = 1'b0;
      repeat (DRAIN_CYCLES) @(posedge clk);
   endtask

   task automatic check_regs(input string name);
      for (int r = 0; r < 4; r++) begin
         rf_read_addr <= 2'(r);
         @(negedge clk);
         assert (rf_read_data == model_regs[r]) else begin
            $display("Fail %s r%0d expected %02h actual %02h",
                     name, r, model_regs[r], rf_read_data);
            test_errs++;
         end
         @(posedge clk);
      end
   endtask

   task automatic finish_test(input string name);
      check_regs(name);
      tests_run++;
      if (test_errs == 0) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d checks wrong", name, test_errs);
      end
      test_errs = 0;
   endtask

   // ------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------
   initial begin
      logic [1:0] prev_rd;
      logic [1:0] older_rd;
      logic [1:0] next_rd;
      logic [1:0] op;
      int         ex_accepts;
      int         wb_accepts;

      void'($urandom(32'hda6f0812));
      rst          <= 1'b1;
      inst         <= '0;
      inst_valid   <= 1'b0;
      stallex      <= 1'b0;
      stallwb      <= 1'b0;
      rf_read_addr <= '0;
      taken        = 1'b0;
      test_errs    = 0;
      tests_run    = 0;
      tests_failed = 0;
      ex_accepts   = 0;
      wb_accepts   = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      @(negedge clk);
      assert (inst_ready) else begin
         $display("inst_ready is low right after reset");
         test_errs++;
      end
      @(posedge clk);
      finish_test("reset_state");

      for (int r = 0; r < SET_INSTS; r++) begin
         send_inst(encode(OPC_SET, 2'($urandom), 2'($urandom), 2'(r)));
      end
      drain_pipe();
      finish_test("set_each");

      // rs1 names the previous destination and rs2 the one before it
      older_rd = 2'($urandom);
      prev_rd  = 2'($urandom);
      for (int n = 0; n < CHAIN_INSTS; n++) begin
         op      = ($urandom % 2) ? OPC_NAND : OPC_ADD;
         next_rd = 2'($urandom);
         send_inst(encode(op, prev_rd, older_rd, next_rd));
         older_rd = prev_rd;
         prev_rd  = next_rd;
      end
      drain_pipe();
      finish_test("dependent_chain");

      for (int n = 0; n < NOP_INSTS; n++) begin
         send_inst(encode(OPC_NOP, 2'($urandom), 2'($urandom), 2'($urandom)));
      end
      drain_pipe();
      finish_test("nop_stream");

      for (int c = 0; c < RAND_CYCLES; c++) begin
         if (!inst_valid || taken) begin
            inst_valid <= ($urandom % 4) != 0;
            inst       <= 8'($urandom);
         end
         // stalls come in bursts so the pipeline fills up
         if (($urandom % 4) == 0) begin
            stallex <= !stallex;
         end
         if (($urandom % 4) == 0) begin
            stallwb <= !stallwb;
         end
         @(negedge clk);
         taken = inst_valid && inst_ready;
         // stallex leaves room for two new items, stallwb for three
         assert (!(stallex && ex_accepts >= 2 && inst_ready)) else begin
            $display("inst_ready high while stallex holds IF/ID and ID/EX full");
            test_errs++;
         end
         assert (!(stallwb && wb_accepts >= 3 && inst_ready)) else begin
            $display("inst_ready high while stallwb holds the whole pipeline full");
            test_errs++;
         end
         ex_accepts = stallex ? ex_accepts + int'(taken) : 0;
         wb_accepts = stallwb ? wb_accepts + int'(taken) : 0;
         @(posedge clk);
      end
      drain_pipe();
      finish_test("random_stalls");

      $display("summary: %0d run, %0d ok, %0d wrong",
               tests_run, tests_run - tests_failed, tests_failed);
      if (tests_failed == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
common/pipe_isa_pkg.sv
common/pipe_ctrl_pkg.sv
common/issue_if.sv
common/fwd_if.sv
hdl/reg_file.sv
hdl/scoreboard.sv
hdl/execute_stage.sv
hdl/decode_stage.sv
hdl/pipe_top.sv
verif/pipe_model.sv
verif/pipe_tb.sv
